//--- cpu_pkg.sv
package cpu_pkg;

    localparam int data_width     = 32;
    localparam int reg_count      = 8;
    localparam int reg_addr_width = 3;
    localparam int instr_width    = 16;

    // Instruction field layout
    localparam int op_msb      = 15;
    localparam int op_lsb      = 12;
    localparam int rd_lsb      = 9;                 // Destination index
    localparam int ra_lsb      = 6;                 // Operand A index
    localparam int imm_sel_bit = 5;                 // Set for immediate B
    localparam int imm_width   = 5;                 // B index uses the low 3 bits

    // NZCV register layout
    localparam int flag_width = 4;
    localparam int flag_n     = 3;
    localparam int flag_z     = 2;
    localparam int flag_c     = 1;
    localparam int flag_v     = 0;

    typedef enum logic [3:0] {
        op_pass_a    = 4'd0,
        op_adc       = 4'd1,
        op_add       = 4'd2,
        op_and       = 4'd3,
        op_bic       = 4'd4,
        op_sub       = 4'd5,
        op_neg       = 4'd6,
        op_or        = 4'd7,
        op_sbc       = 4'd8,
        op_mul       = 4'd9,
        op_div       = 4'd10,
        op_mod       = 4'd11,
        op_pass_b    = 4'd12,                       // Move B
        op_xor       = 4'd13,
        op_land      = 4'd14,
        op_flag_load = 4'd15                        // NZCV from A[3:0]
    } alu_op_e;

endpackage

//--- alu.sv
`timescale 1ns/1ps

module alu (
    input  logic [cpu_pkg::data_width-1:0] channel_a,
    input  logic [cpu_pkg::data_width-1:0] channel_b,
    input  cpu_pkg::alu_op_e               control,
    input  logic                           previous_carry,
    output logic [cpu_pkg::data_width-1:0] operation_result,
    output logic                           negative_flag,
    output logic                           zero_flag,
    output logic                           carry_flag,
    output logic                           overflow_flag
);

    logic [cpu_pkg::data_width:0]   wide_sum;       // Extra top bit is carry out
    logic [cpu_pkg::data_width-1:0] neg_a;
    logic [cpu_pkg::data_width-1:0] neg_b;
    logic [cpu_pkg::data_width-1:0] eff_a;
    logic [cpu_pkg::data_width-1:0] eff_b;
    logic                           borrow_in;
    logic                           sign_overflow;

    assign neg_a     = -channel_a;
    assign neg_b     = -channel_b;
    assign borrow_in = ~previous_carry;

    // Adder path and the operands seen by the sign rule
    always_comb
    begin
        eff_a = channel_a;
        eff_b = channel_b;
        case (control)
            cpu_pkg::op_adc:
            begin
                wide_sum = {1'b0, channel_a} + {1'b0, channel_b}
                           + {{cpu_pkg::data_width{1'b0}}, previous_carry};
            end
            cpu_pkg::op_add:
            begin
                wide_sum = {1'b0, channel_a} + {1'b0, channel_b};
            end
            cpu_pkg::op_sub:
            begin
                eff_b    = neg_b;
                wide_sum = {1'b0, channel_a} + {1'b0, neg_b};
            end
            cpu_pkg::op_neg:
            begin
                eff_a    = '0;                      // Computed as 0 - A
                eff_b    = neg_a;
                wide_sum = -{1'b0, channel_a};
            end
            cpu_pkg::op_sbc:
            begin
                eff_b    = ~channel_b;              // A + ~B + C
                wide_sum = {1'b0, channel_a} - {1'b0, channel_b}
                           - {{cpu_pkg::data_width{1'b0}}, borrow_in};
            end
            default:
            begin
                wide_sum = {1'b0, channel_a};
            end
        endcase
    end

    // Operands of like sign giving a result of the other sign
    assign sign_overflow = (eff_a[cpu_pkg::data_width-1] == eff_b[cpu_pkg::data_width-1])
                           && (wide_sum[cpu_pkg::data_width-1] != eff_a[cpu_pkg::data_width-1]);

    always_comb
    begin
        operation_result = '0;
        negative_flag    = 1'b0;
        carry_flag       = 1'b0;
        overflow_flag    = 1'b0;
        case (control)
            cpu_pkg::op_adc, cpu_pkg::op_add, cpu_pkg::op_sub,
            cpu_pkg::op_neg, cpu_pkg::op_sbc:
            begin
                operation_result = wide_sum[cpu_pkg::data_width-1:0];
                negative_flag    = wide_sum[cpu_pkg::data_width-1];
                carry_flag       = wide_sum[cpu_pkg::data_width];
                overflow_flag    = sign_overflow;
            end
            cpu_pkg::op_and:
            begin
                operation_result = channel_a & channel_b;
                negative_flag    = operation_result[cpu_pkg::data_width-1];
            end
            cpu_pkg::op_bic:
            begin
                operation_result = channel_a & ~channel_b;
                negative_flag    = operation_result[cpu_pkg::data_width-1];
            end
            cpu_pkg::op_or:
            begin
                operation_result = channel_a | channel_b;
                negative_flag    = operation_result[cpu_pkg::data_width-1];
            end
            cpu_pkg::op_xor:
            begin
                operation_result = channel_a ^ channel_b;
                negative_flag    = operation_result[cpu_pkg::data_width-1];
            end
            cpu_pkg::op_mul:
            begin
                operation_result = channel_a * channel_b;   // Low word only
                negative_flag    = operation_result[cpu_pkg::data_width-1];
            end
            cpu_pkg::op_div:
            begin
                overflow_flag    = (channel_b == '0);
                operation_result = overflow_flag ? '0 : channel_a / channel_b;
            end
            cpu_pkg::op_mod:
            begin
                overflow_flag    = (channel_b == '0);
                operation_result = overflow_flag ? '0 : channel_a % channel_b;
            end
            cpu_pkg::op_pass_b:
            begin
                operation_result = channel_b;
            end
            cpu_pkg::op_land:
            begin
                operation_result = {{(cpu_pkg::data_width-1){1'b0}},
                                    (channel_a != '0) && (channel_b != '0)};
            end
            cpu_pkg::op_flag_load:
            begin
                negative_flag = channel_a[cpu_pkg::flag_n];
                carry_flag    = channel_a[cpu_pkg::flag_c];
                overflow_flag = channel_a[cpu_pkg::flag_v];
            end
            default:                                // Pass A
            begin
                operation_result = channel_a;
                negative_flag    = operation_result[cpu_pkg::data_width-1];
            end
        endcase
        // Z is loaded like the other flags for flag_load
        if (control == cpu_pkg::op_flag_load)
        begin
            zero_flag = channel_a[cpu_pkg::flag_z];
        end
        else
        begin
            zero_flag = (operation_result == '0);
        end
    end

endmodule

//--- register_bank.sv
`timescale 1ns/1ps

module register_bank (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic [cpu_pkg::reg_addr_width-1:0] rd_addr_a,
    input  logic [cpu_pkg::reg_addr_width-1:0] rd_addr_b,
    input  logic                               wr_en,
    input  logic [cpu_pkg::reg_addr_width-1:0] wr_addr,
    input  logic [cpu_pkg::data_width-1:0]     wr_data,
    output logic [cpu_pkg::data_width-1:0]     rd_data_a,
    output logic [cpu_pkg::data_width-1:0]     rd_data_b
);

    logic [cpu_pkg::data_width-1:0] regs [cpu_pkg::reg_count];

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            for (int i = 0; i < cpu_pkg::reg_count; i++)
            begin
                regs[i] <= '0;
            end
        end
        else if (wr_en)
        begin
            regs[wr_addr] <= wr_data;
        end
    end

    // Write-through so the next instruction sees this cycle's result
    assign rd_data_a = (wr_en && (wr_addr == rd_addr_a)) ? wr_data : regs[rd_addr_a];
    assign rd_data_b = (wr_en && (wr_addr == rd_addr_b)) ? wr_data : regs[rd_addr_b];

    wr_addr_known: assert property (
        @(posedge clk) disable iff (!rst_n)
        wr_en |-> !$isunknown(wr_addr)
    ) else $error("register_bank write with unknown address");

endmodule

//--- instr_decode.sv
`timescale 1ns/1ps

module instr_decode (
    input  logic                               instr_valid,
    input  logic [cpu_pkg::instr_width-1:0]    instr,
    input  logic [cpu_pkg::data_width-1:0]     rd_data_a,
    input  logic [cpu_pkg::data_width-1:0]     rd_data_b,
    output logic [cpu_pkg::reg_addr_width-1:0] rd_addr_a,
    output logic [cpu_pkg::reg_addr_width-1:0] rd_addr_b,
    output logic                               dec_valid,
    output cpu_pkg::alu_op_e                   dec_op,
    output logic [cpu_pkg::reg_addr_width-1:0] dec_dest,
    output logic [cpu_pkg::data_width-1:0]     dec_operand_a,
    output logic [cpu_pkg::data_width-1:0]     dec_operand_b
);

    logic                              use_imm;
    logic [cpu_pkg::imm_width-1:0]     imm_field;
    logic [cpu_pkg::data_width-1:0]    imm_value;

    assign use_imm   = instr[cpu_pkg::imm_sel_bit];
    assign imm_field = instr[cpu_pkg::imm_width-1:0];

    // Unsigned immediate
    assign imm_value = {{(cpu_pkg::data_width-cpu_pkg::imm_width){1'b0}}, imm_field};

    assign rd_addr_a = instr[cpu_pkg::ra_lsb +: cpu_pkg::reg_addr_width];
    assign rd_addr_b = instr[cpu_pkg::reg_addr_width-1:0];   // Low bits of imm field

    assign dec_valid     = instr_valid;
    assign dec_op        = cpu_pkg::alu_op_e'(instr[cpu_pkg::op_msb:cpu_pkg::op_lsb]);
    assign dec_dest      = instr[cpu_pkg::rd_lsb +: cpu_pkg::reg_addr_width];
    assign dec_operand_a = rd_data_a;
    assign dec_operand_b = use_imm ? imm_value : rd_data_b;

endmodule

//--- id_ex_stage.sv
`timescale 1ns/1ps

module id_ex_stage (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic                               dec_valid,
    input  cpu_pkg::alu_op_e                   dec_op,
    input  logic [cpu_pkg::reg_addr_width-1:0] dec_dest,
    input  logic [cpu_pkg::data_width-1:0]     dec_operand_a,
    input  logic [cpu_pkg::data_width-1:0]     dec_operand_b,
    output logic                               ex_valid,
    output cpu_pkg::alu_op_e                   ex_op,
    output logic [cpu_pkg::reg_addr_width-1:0] ex_dest,
    output logic [cpu_pkg::data_width-1:0]     ex_operand_a,
    output logic [cpu_pkg::data_width-1:0]     ex_operand_b
);

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            ex_valid <= 1'b0;
        end
        else
        begin
            ex_valid <= dec_valid;
        end
    end

    // Payload holds its value through idle cycles
    always_ff @(posedge clk)
    begin
        if (dec_valid)
        begin
            ex_op        <= dec_op;
            ex_dest      <= dec_dest;
            ex_operand_a <= dec_operand_a;
            ex_operand_b <= dec_operand_b;
        end
    end

    ex_valid_known: assert property (
        @(posedge clk) disable iff (!rst_n)
        !$isunknown(ex_valid)
    ) else $error("id_ex_stage valid bit is unknown");

endmodule

//--- exec_stage.sv
`timescale 1ns/1ps

module exec_stage (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic                               ex_valid,
    input  cpu_pkg::alu_op_e                   ex_op,
    input  logic [cpu_pkg::reg_addr_width-1:0] ex_dest,
    input  logic [cpu_pkg::data_width-1:0]     ex_operand_a,
    input  logic [cpu_pkg::data_width-1:0]     ex_operand_b,
    output logic                               wr_en,
    output logic [cpu_pkg::reg_addr_width-1:0] wr_addr,
    output logic [cpu_pkg::data_width-1:0]     wr_data,
    output logic                               result_valid,
    output logic [cpu_pkg::data_width-1:0]     result_data,
    output logic [cpu_pkg::reg_addr_width-1:0] result_dest,
    output logic [cpu_pkg::flag_width-1:0]     flags
);

    logic [cpu_pkg::flag_width-1:0] nzcv;
    logic [cpu_pkg::data_width-1:0] alu_result;
    logic                           alu_n;
    logic                           alu_z;
    logic                           alu_c;
    logic                           alu_v;

    alu alu_i (
        .channel_a        (ex_operand_a),
        .channel_b        (ex_operand_b),
        .control          (ex_op),
        .previous_carry   (nzcv[cpu_pkg::flag_c]),
        .operation_result (alu_result),
        .negative_flag    (alu_n),
        .zero_flag        (alu_z),
        .carry_flag       (alu_c),
        .overflow_flag    (alu_v)
    );

    // Flag load touches no register
    assign wr_en   = ex_valid && (ex_op != cpu_pkg::op_flag_load);
    assign wr_addr = ex_dest;
    assign wr_data = alu_result;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            nzcv         <= '0;
            result_valid <= 1'b0;
        end
        else
        begin
            result_valid <= ex_valid;
            if (ex_valid)
            begin
                nzcv[cpu_pkg::flag_n] <= alu_n;
                nzcv[cpu_pkg::flag_z] <= alu_z;
                nzcv[cpu_pkg::flag_c] <= alu_c;
                nzcv[cpu_pkg::flag_v] <= alu_v;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (ex_valid)
        begin
            result_data <= alu_result;              // Zero for flag load
            result_dest <= ex_dest;
        end
    end

    assign flags = nzcv;

endmodule

//--- exec_slice_top.sv
`timescale 1ns/1ps

module exec_slice_top (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic                               instr_valid,
    input  logic [cpu_pkg::instr_width-1:0]    instr,
    output logic                               result_valid,
    output logic [cpu_pkg::data_width-1:0]     result_data,
    output logic [cpu_pkg::reg_addr_width-1:0] result_dest,
    output logic [cpu_pkg::flag_width-1:0]     flags
);

    logic [cpu_pkg::reg_addr_width-1:0] rd_addr_a;
    logic [cpu_pkg::reg_addr_width-1:0] rd_addr_b;
    logic [cpu_pkg::data_width-1:0]     rd_data_a;
    logic [cpu_pkg::data_width-1:0]     rd_data_b;

    logic                               dec_valid;
    cpu_pkg::alu_op_e                   dec_op;
    logic [cpu_pkg::reg_addr_width-1:0] dec_dest;
    logic [cpu_pkg::data_width-1:0]     dec_operand_a;
    logic [cpu_pkg::data_width-1:0]     dec_operand_b;

    logic                               ex_valid;
    cpu_pkg::alu_op_e                   ex_op;
    logic [cpu_pkg::reg_addr_width-1:0] ex_dest;
    logic [cpu_pkg::data_width-1:0]     ex_operand_a;
    logic [cpu_pkg::data_width-1:0]     ex_operand_b;

    logic                               wr_en;
    logic [cpu_pkg::reg_addr_width-1:0] wr_addr;
    logic [cpu_pkg::data_width-1:0]     wr_data;

    instr_decode instr_decode_i (
        .instr_valid   (instr_valid),
        .instr         (instr),
        .rd_data_a     (rd_data_a),
        .rd_data_b     (rd_data_b),
        .rd_addr_a     (rd_addr_a),
        .rd_addr_b     (rd_addr_b),
        .dec_valid     (dec_valid),
        .dec_op        (dec_op),
        .dec_dest      (dec_dest),
        .dec_operand_a (dec_operand_a),
        .dec_operand_b (dec_operand_b)
    );

    register_bank register_bank_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .rd_addr_a (rd_addr_a),
        .rd_addr_b (rd_addr_b),
        .wr_en     (wr_en),
        .wr_addr   (wr_addr),
        .wr_data   (wr_data),
        .rd_data_a (rd_data_a),
        .rd_data_b (rd_data_b)
    );

    id_ex_stage id_ex_stage_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .dec_valid     (dec_valid),
        .dec_op        (dec_op),
        .dec_dest      (dec_dest),
        .dec_operand_a (dec_operand_a),
        .dec_operand_b (dec_operand_b),
        .ex_valid      (ex_valid),
        .ex_op         (ex_op),
        .ex_dest       (ex_dest),
        .ex_operand_a  (ex_operand_a),
        .ex_operand_b  (ex_operand_b)
    );

    exec_stage exec_stage_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .ex_valid     (ex_valid),
        .ex_op        (ex_op),
        .ex_dest      (ex_dest),
        .ex_operand_a (ex_operand_a),
        .ex_operand_b (ex_operand_b),
        .wr_en        (wr_en),
        .wr_addr      (wr_addr),
        .wr_data      (wr_data),
        .result_valid (result_valid),
        .result_data  (result_data),
        .result_dest  (result_dest),
        .flags        (flags)
    );

endmodule

//--- tb_exec_slice.sv
`timescale 1ns/1ps

module tb_exec_slice;

    localparam int timeout_cycles = 400;            // ~300 instructions plus idle gaps

    logic                                   clk;
    logic                                   rst_n;
    logic                                   instr_valid;
    logic [cpu_pkg::instr_width-1:0]        instr;
    logic                                   result_valid;
    logic [cpu_pkg::data_width-1:0]         result_data;
    logic [cpu_pkg::reg_addr_width-1:0]     result_dest;
    logic [cpu_pkg::flag_width-1:0]         flags;

    logic [cpu_pkg::data_width-1:0]         mirror [cpu_pkg::reg_count];
    logic [cpu_pkg::flag_width-1:0]         mirror_flags;
    logic [cpu_pkg::data_width-1:0]         data_q [$];
    logic [cpu_pkg::reg_addr_width-1:0]     dest_q [$];
    logic [cpu_pkg::flag_width-1:0]         flags_q [$];
    logic                                   fl_q [$];
    logic [cpu_pkg::data_width-1:0]         exp_data;
    logic [cpu_pkg::reg_addr_width-1:0]     exp_dest;
    logic [cpu_pkg::flag_width-1:0]         exp_flags;
    logic                                   exp_fl;
    integer                                 seed;
    integer                                 cycle_count;

    exec_slice_top dut_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .instr_valid  (instr_valid),
        .instr        (instr),
        .result_valid (result_valid),
        .result_data  (result_data),
        .result_dest  (result_dest),
        .flags        (flags)
    );

    initial
    begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic report_mismatch(input string name, input logic [31:0] expv,
                                   input logic [31:0] got);
        $display("FAIL time=%0t signal=%s expected=%h observed=%h", $time, name, expv, got);
        $display("=== FAIL ===");
        $fatal(1, "mismatch on %s", name);
    endtask

    task automatic report_error(input string what);
        $display("%s at time %0t", what, $time);
        $display("=== FAIL ===");
        $fatal(1, "%s", what);
    endtask

    // Reference model of one instruction
    task automatic model_exec(input cpu_pkg::alu_op_e op, input logic [31:0] a,
                              input logic [31:0] b, input logic [3:0] f_in,
                              output logic [31:0] r, output logic [3:0] f_out);
        logic [32:0] w;
        logic [31:0] ea;
        logic [31:0] eb;
        logic        arith;
        ea    = a;
        eb    = b;
        arith = 1'b1;
        w     = '0;
        f_out = 4'b0000;
        case (op)
            cpu_pkg::op_add: w = {1'b0, a} + {1'b0, b};
            cpu_pkg::op_adc: w = {1'b0, a} + {1'b0, b} + {32'd0, f_in[1]};
            cpu_pkg::op_sub:
            begin
                eb = 32'd0 - b;
                w  = {1'b0, a} + {1'b0, eb};
            end
            cpu_pkg::op_neg:
            begin
                ea = '0;
                eb = 32'd0 - a;
                w  = 33'd0 - {1'b0, a};             // C is the borrow of 0 - A
            end
            cpu_pkg::op_sbc:
            begin
                eb = ~b;
                w  = {1'b0, a} - {1'b0, b} - {32'd0, !f_in[1]};
            end
            default: arith = 1'b0;
        endcase
        r = w[31:0];
        if (arith)
        begin
            f_out[3] = r[31];
            f_out[1] = w[32];
            f_out[0] = (ea[31] == eb[31]) && (r[31] != ea[31]);
        end
        else
        begin
            case (op)
                cpu_pkg::op_and:    r = a & b;
                cpu_pkg::op_bic:    r = a & ~b;
                cpu_pkg::op_or:     r = a | b;
                cpu_pkg::op_xor:    r = a ^ b;
                cpu_pkg::op_mul:    r = a * b;
                cpu_pkg::op_div:    r = (b == 0) ? 32'd0 : a / b;
                cpu_pkg::op_mod:    r = (b == 0) ? 32'd0 : a % b;
                cpu_pkg::op_pass_b: r = b;
                cpu_pkg::op_land:   r = {31'd0, (a != 0) && (b != 0)};
                cpu_pkg::op_pass_a: r = a;
                default:            r = '0;
            endcase
            if (op inside {cpu_pkg::op_and, cpu_pkg::op_bic, cpu_pkg::op_or,
                           cpu_pkg::op_xor, cpu_pkg::op_mul, cpu_pkg::op_pass_a})
            begin
                f_out[3] = r[31];
            end
            if (op inside {cpu_pkg::op_div, cpu_pkg::op_mod})
            begin
                f_out[0] = (b == 0);                // Divide by zero
            end
        end
        f_out[2] = (r == 0);
        if (op == cpu_pkg::op_flag_load)
        begin
            f_out = a[3:0];
        end
    endtask

    // Drive one instruction on the falling edge and record what it should give
    task automatic issue(input cpu_pkg::alu_op_e op, input logic [2:0] rd,
                         input logic [2:0] ra, input logic use_imm, input logic [4:0] bfield);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] r;
        logic [3:0]  f;
        a = mirror[ra];
        b = use_imm ? {27'd0, bfield} : mirror[bfield[2:0]];
        model_exec(op, a, b, mirror_flags, r, f);
        if (op != cpu_pkg::op_flag_load)
        begin
            mirror[rd] = r;
        end
        mirror_flags = f;
        data_q.push_back(r);
        dest_q.push_back(rd);
        flags_q.push_back(f);
        fl_q.push_back(op == cpu_pkg::op_flag_load);
        @(negedge clk);
        instr_valid = 1'b1;
        instr       = {op, rd, ra, use_imm, bfield};
    endtask

    task automatic idle(input int n);
        repeat (n)
        begin
            @(negedge clk);
            instr_valid = 1'b0;
        end
    endtask

    // Builds a value five bits at a time using r7 as 32
    task automatic load_reg(input logic [2:0] rd, input logic [31:0] val);
        issue(cpu_pkg::op_pass_b, rd, 3'd0, 1'b1, {3'd0, val[31:30]});
        for (int k = 5; k >= 0; k--)
        begin
            issue(cpu_pkg::op_mul, rd, rd, 1'b0, 5'd7);
            issue(cpu_pkg::op_add, rd, rd, 1'b1, val[k*5 +: 5]);
        end
    endtask

    // Expected values move to the head as each result appears
    always @(negedge clk)
    begin
        if (rst_n && result_valid)
        begin
            if (data_q.size() == 0)
            begin
                report_error("result arrived with nothing expected");
            end
            else
            begin
                exp_data  <= data_q.pop_front();
                exp_dest  <= dest_q.pop_front();
                exp_flags <= flags_q.pop_front();
                exp_fl    <= fl_q.pop_front();
            end
        end
    end

    data_check: assert property (@(posedge clk) disable iff (!rst_n)
        (result_valid && !exp_fl) |-> (result_data == exp_data))
        else report_mismatch("result_data", exp_data, result_data);

    dest_check: assert property (@(posedge clk) disable iff (!rst_n)
        (result_valid && !exp_fl) |-> (result_dest == exp_dest))
        else report_mismatch("result_dest", exp_dest, result_dest);

    flags_check: assert property (@(posedge clk) disable iff (!rst_n)
        result_valid |-> (flags == exp_flags))
        else report_mismatch("flags", exp_flags, flags);

    latency_check: assert property (@(posedge clk) disable iff (!rst_n)
        instr_valid |-> ##2 result_valid)
        else report_error("result_valid missing one edge after an accepted instruction");

    no_spurious_result: assert property (@(posedge clk) disable iff (!rst_n)
        result_valid |-> $past(instr_valid, 2))
        else report_error("result_valid high without an instruction");

    always @(posedge clk)
    begin
        if (rst_n)
        begin
            cycle_count <= cycle_count + 1;
            if (cycle_count >= timeout_cycles)
            begin
                report_error("timeout: results stopped arriving");
            end
        end
    end

    initial
    begin
        logic [31:0] vals [6];
        cpu_pkg::alu_op_e arith_ops [5];
        cpu_pkg::alu_op_e logic_ops [5];
        seed         = 3096;
        cycle_count  = 0;
        rst_n        = 1'b0;
        instr_valid  = 1'b0;
        instr        = '0;
        exp_data     = '0;
        exp_dest     = '0;
        exp_flags    = '0;
        exp_fl       = 1'b0;
        mirror_flags = '0;
        for (int i = 0; i < cpu_pkg::reg_count; i++)
        begin
            mirror[i] = '0;
        end
        arith_ops = '{cpu_pkg::op_add, cpu_pkg::op_adc, cpu_pkg::op_sub,
                      cpu_pkg::op_sbc, cpu_pkg::op_neg};
        logic_ops = '{cpu_pkg::op_and, cpu_pkg::op_bic, cpu_pkg::op_or,
                      cpu_pkg::op_xor, cpu_pkg::op_land};
        vals = '{32'h0000_0000, 32'hffff_ffff, 32'h8000_0000, 32'h7fff_ffff, 32'h0, 32'h0};
        vals[4] = $random(seed);
        vals[5] = $random(seed);
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        // Reset state
        repeat (2)
        begin
            @(negedge clk);
            reset_idle: assert (!result_valid && flags == 4'b0000)
                else report_error("outputs not idle after reset");
        end
        issue(cpu_pkg::op_pass_a, 3'd0, 3'd1, 1'b0, 5'd0);
        issue(cpu_pkg::op_pass_b, 3'd7, 3'd0, 1'b1, 5'd16);
        issue(cpu_pkg::op_add, 3'd7, 3'd7, 1'b0, 5'd7);
        for (int i = 0; i < 6; i++)
        begin
            load_reg(3'(i + 1), vals[i]);
        end

        for (int i = 0; i < 5; i++)
        begin
            for (int j = 1; j <= 6; j++)
            begin
                issue(arith_ops[i], 3'd0, 3'(j), 1'b0, 5'((j % 6) + 1));
                issue(arith_ops[i], 3'd0, 3'((j % 6) + 1), 1'b0, 5'(j));   // Uses the carry above
                issue(logic_ops[i], 3'd0, 3'(j), 1'b0, 5'(((j + 2) % 6) + 1));
            end
        end
        for (int j = 1; j <= 6; j++)
        begin
            issue(cpu_pkg::op_mul, 3'd0, 3'(j), 1'b0, 5'((j % 6) + 1));
            issue(cpu_pkg::op_div, 3'd0, 3'(j), 1'b0, 5'((j % 6) + 1));
            issue(cpu_pkg::op_mod, 3'd0, 3'(j), 1'b1, 5'(j + 3));
        end
        issue(cpu_pkg::op_div, 3'd0, 3'd5, 1'b1, 5'd0);
        issue(cpu_pkg::op_mod, 3'd0, 3'd6, 1'b1, 5'd0);

        // Back-to-back dependencies and idle gaps
        issue(cpu_pkg::op_add, 3'd0, 3'd5, 1'b0, 5'd6);
        issue(cpu_pkg::op_sub, 3'd0, 3'd0, 1'b0, 5'd6);
        issue(cpu_pkg::op_adc, 3'd0, 3'd0, 1'b0, 5'd5);
        issue(cpu_pkg::op_sbc, 3'd0, 3'd0, 1'b0, 5'd2);
        idle(2);
        issue(cpu_pkg::op_xor, 3'd0, 3'd0, 1'b0, 5'd5);
        idle(1);
        issue(cpu_pkg::op_mul, 3'd0, 3'd0, 1'b0, 5'd0);
        idle(3);

        // Flag loading, each pattern followed by an adc
        for (int p = 0; p < 16; p++)
        begin
            issue(cpu_pkg::op_pass_b, 3'd0, 3'd0, 1'b1, 5'(p));
            issue(cpu_pkg::op_flag_load, 3'd3, 3'd0, 1'b0, 5'd0);
            issue(cpu_pkg::op_adc, 3'd0, 3'd2, 1'b0, 5'd2);
        end
        idle(4);

        if (data_q.size() != 0)
        begin
            $display("expected results never arrived: %0d left", data_q.size());
            $display("=== FAIL ===");
            $fatal(1, "results missing");
        end
        else
        begin
            $display("=== PASS ===");
            $finish;
        end
    end

endmodule

//--- verilog.f
cpu_pkg.sv
alu.sv
register_bank.sv
instr_decode.sv
id_ex_stage.sv
exec_stage.sv
exec_slice_top.sv
tb_exec_slice.sv
